//--- src.f
+incdir+.
rt_pkg.sv
specular_reflect.sv
diffuse_scatter.sv
reflect_blend.sv
ray_reflector.sv
tb_ray_reflector.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ray_reflector
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
PASS_MSG  ?= NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message appears on a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_ray_reflector.sv
`timescale 1ns/10ps
`default_nettype none

`include "rt_defs.svh"

module tb_ray_reflector;
  import rt_pkg::*;

  localparam int NUM_HITS    = 66;
  localparam int CLK_NS      = 40;
  localparam int WATCHDOG_NS = (NUM_HITS + 20) * CLK_NS * 2;
  localparam int LAT         = `RT_DIR_LAT + `RT_BLEND_LAT;

  typedef struct packed {
    vec3_t       dir;
    vec3_t       origin;
    color_t      color;
    color_t      light;
    logic [31:0] due;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        hit_valid;
  vec3_t       ray_dir;
  color_t      ray_color;
  color_t      income_light;
  vec3_t       hit_pos;
  vec3_t       hit_normal;
  material_t   hit_mat;
  logic [47:0] lfsr_seed;
  vec3_t       new_dir;
  vec3_t       new_origin;
  color_t      new_color;
  color_t      new_income_light;
  logic        reflect_done;

  expect_t     exp_q[$];
  expect_t     head;
  logic [31:0] cycle = '0;
  logic [31:0] rng;
  logic [47:0] gen;
  int          checks = 0;
  int          errors = 0;

  ray_reflector UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
    checks++;
    if (got !== want) begin
      $display("error: %s is %h, expected %h", name, got, want);
      errors++;
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Software copy of the hardware generator
  function automatic logic [47:0] galois_step(input logic [47:0] s);
    return s[0] ? ((s >> 1) ^ `RT_LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic fix_t mirror_comp(input fix_t d, input fix_t dot, input fix_t n);
    return d - fix_t'((longint'(2) * dot * n) >>> 14);
  endfunction

  function automatic fix_t scatter_comp(input fix_t n, input logic [15:0] r);
    return n + (fix_t'(r) >>> 2);
  endfunction

  function automatic fix_t blend_comp(input fix_t s, input fix_t df, input logic [6:0] k);
    fix_t delta;
    delta = s - df;
    return df + fix_t'((int'(delta) * int'(k)) >>> 7);
  endfunction

  function automatic color_t scale(input color_t a, input color_t b);
    color_t c;
    c.r = 8'((16'(a.r) * 16'(b.r)) >> 8);
    c.g = 8'((16'(a.g) * 16'(b.g)) >> 8);
    c.b = 8'((16'(a.b) * 16'(b.b)) >> 8);
    return c;
  endfunction

  function automatic logic [7:0] sat(input logic [7:0] a, input logic [7:0] b);
    int s;
    s = int'(a) + int'(b);
    return (s > 255) ? 8'hFF : 8'(s);
  endfunction

  // Expected outputs of one hit, st is the generator state before its step
  function automatic expect_t predict(input vec3_t d, input color_t rc, input color_t il,
                                      input vec3_t p, input vec3_t n, input material_t m,
                                      input logic [47:0] st);
    expect_t e;
    vec3_t   spec;
    color_t  glow;
    fix_t    dot;
    e = '0;
    dot = fix_t'((longint'(d.x) * n.x + longint'(d.y) * n.y + longint'(d.z) * n.z) >>> 14);
    spec.x = mirror_comp(d.x, dot, n.x);
    spec.y = mirror_comp(d.y, dot, n.y);
    spec.z = mirror_comp(d.z, dot, n.z);
    e.dir.x = scatter_comp(n.x, st[47:32]);
    e.dir.y = scatter_comp(n.y, st[31:16]);
    e.dir.z = scatter_comp(n.z, st[15:0]);
    e.light = il;
    if (m.emit.kind) begin
      e.color = scale(rc, m.emit.color);
      glow = scale(rc, m.emit.emit_color);
      e.light.r = sat(il.r, glow.r);
      e.light.g = sat(il.g, glow.g);
      e.light.b = sat(il.b, glow.b);
    end else if (st[7:0] < m.surf.spec_prob) begin
      e.dir.x = blend_comp(spec.x, e.dir.x, m.surf.smoothness);
      e.dir.y = blend_comp(spec.y, e.dir.y, m.surf.smoothness);
      e.dir.z = blend_comp(spec.z, e.dir.z, m.surf.smoothness);
      e.color = scale(rc, m.surf.spec_color);
    end else begin
      e.color = scale(rc, m.surf.color);
    end
    e.origin.x = p.x + (n.x >>> `RT_ORIGIN_SHIFT);
    e.origin.y = p.y + (n.y >>> `RT_ORIGIN_SHIFT);
    e.origin.z = p.z + (n.z >>> `RT_ORIGIN_SHIFT);
    return e;
  endfunction

  // Components kept within about +-1.0
  function automatic vec3_t rand_vec();
    logic [31:0] a;
    logic [31:0] b;
    vec3_t       v;
    a = next_rand();
    b = next_rand();
    v.x = fix_t'(a[15:0]) >>> 1;
    v.y = fix_t'(a[31:16]) >>> 1;
    v.z = fix_t'(b[15:0]) >>> 1;
    return v;
  endfunction

  function automatic color_t rand_color();
    return color_t'(24'(next_rand()));
  endfunction

  function automatic material_t make_surface(input logic [7:0] prob, input logic [6:0] smooth);
    material_t m;
    m = '0;
    m.surf.color      = rand_color();
    m.surf.spec_color = rand_color();
    m.surf.spec_prob  = prob;
    m.surf.smoothness = smooth;
    return m;
  endfunction

  function automatic material_t make_emit(input color_t glow, input color_t base);
    material_t m;
    m = '0;
    m.emit.kind       = 1'b1;
    m.emit.emit_color = glow;
    m.emit.color      = base;
    return m;
  endfunction

  function automatic material_t rand_material();
    logic [31:0] r;
    material_t   m;
    r = next_rand();
    if (r[0]) begin
      m = make_emit(rand_color(), rand_color());
      // Unused bits overlap the surface probability and smoothness
      m.emit.rsvd = r[31:17];
      return m;
    end
    return make_surface(r[15:8], r[22:16]);
  endfunction

  task automatic send_hit(input vec3_t d, input color_t rc, input color_t il,
                          input vec3_t p, input vec3_t n, input material_t m);
    expect_t e;
    @(negedge clk);
    ray_dir      = d;
    ray_color    = rc;
    income_light = il;
    hit_pos      = p;
    hit_normal   = n;
    hit_mat      = m;
    hit_valid    = 1'b1;
    e = predict(d, rc, il, p, n, m, gen);
    // Done rises LAT rising edges from here, seen at the falling edge after
    e.due = cycle + LAT;
    exp_q.push_back(e);
    gen = galois_step(gen);
  endtask

  task automatic send_random();
    send_hit(rand_vec(), rand_color(), rand_color(), rand_vec(), rand_vec(), rand_material());
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      hit_valid = 1'b0;
    end
  endtask

  task automatic finish_test(input string name, input int start);
    int waited;
    idle(1);
    waited = 0;
    while (exp_q.size() != 0 && waited < 4 * LAT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d hits never produced reflect_done", name, exp_q.size());
      errors += exp_q.size();
      exp_q.delete();
    end
    $display("test %s: %0d errors", name, errors - start);
  endtask

  // Outputs settle after the rising edge, so compare on the falling one
  always @(negedge clk) begin
    if (reflect_done === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("reflect_done at cycle %0d with no hit pending", cycle);
        errors++;
      end else begin
        head = exp_q.pop_front();
        if (head.due != cycle) begin
          $display("reflect_done at cycle %0d, its hit expected it at cycle %0d",
                   cycle, head.due);
          errors++;
        end
        check("new_dir", new_dir, head.dir);
        check("new_origin", new_origin, head.origin);
        check("new_color", new_color, head.color);
        check("new_income_light", new_income_light, head.light);
      end
    end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
      $display("reflect_done missing at cycle %0d", cycle);
      errors++;
      void'(exp_q.pop_front());
    end
  end

  task automatic test_reset();
    int start;
    start = errors;
    repeat (4) begin
      @(negedge clk);
      check("reflect_done", reflect_done, 1'b0);
    end
    rst_n = 1'b1;
    repeat (LAT) begin
      @(negedge clk);
      check("reflect_done", reflect_done, 1'b0);
    end
    $display("test reset: %0d errors", errors - start);
  endtask

  task automatic test_mirror();
    int start;
    start = errors;
    repeat (8) begin
      send_hit(rand_vec(), rand_color(), rand_color(), rand_vec(), rand_vec(),
               make_surface(8'd255, 7'd127));
    end
    finish_test("mirror bounce", start);
  endtask

  task automatic test_diffuse();
    int start;
    start = errors;
    repeat (8) begin
      send_hit(rand_vec(), rand_color(), rand_color(), rand_vec(), rand_vec(),
               make_surface(8'd0, 7'(next_rand())));
    end
    finish_test("pure diffuse", start);
  endtask

  task automatic test_emissive();
    int start;
    start = errors;
    // Small glow, then one that clips two channels
    send_hit(rand_vec(), 24'h404040, 24'h101010, rand_vec(), rand_vec(),
             make_emit(24'h202020, 24'h80C0FF));
    send_hit(rand_vec(), 24'hFFFFFF, 24'hC0F000, rand_vec(), rand_vec(),
             make_emit(24'hFF80FF, 24'h102030));
    finish_test("emissive hit", start);
  endtask

  task automatic test_origin();
    int start;
    start = errors;
    repeat (8) send_random();
    finish_test("origin offset", start);
  endtask

  task automatic test_streaming();
    int start;
    start = errors;
    repeat (30) send_random();
    // Gaps show the generator holds while no hit enters
    repeat (10) begin
      idle(1 + int'(next_rand() & 32'd1));
      send_random();
    end
    finish_test("streaming", start);
  endtask

  initial begin
    rst_n        = 1'b0;
    hit_valid    = 1'b0;
    ray_dir      = '0;
    ray_color    = '0;
    income_light = '0;
    hit_pos      = '0;
    hit_normal   = '0;
    hit_mat      = '0;
    lfsr_seed    = 48'd29;
    rng          = 32'd29;
    gen          = 48'd29;
    test_reset();
    test_mirror();
    test_diffuse();
    test_emissive();
    test_origin();
    test_streaming();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ray_reflector.sv
`timescale 1ns/10ps
`default_nettype none

module ray_reflector (
  input  wire                    clk,
  input  wire                    rst_n,

  input  wire                    hit_valid,
  input  wire rt_pkg::vec3_t     ray_dir,
  input  wire rt_pkg::color_t    ray_color,
  input  wire rt_pkg::color_t    income_light,
  input  wire rt_pkg::vec3_t     hit_pos,
  input  wire rt_pkg::vec3_t     hit_normal,
  input  wire rt_pkg::material_t hit_mat,

  // Loaded into the generator during reset
  input  wire [47:0]             lfsr_seed,

  output rt_pkg::vec3_t          new_dir,
  output rt_pkg::vec3_t          new_origin,
  output rt_pkg::color_t         new_color,
  output rt_pkg::color_t         new_income_light,
  output logic                   reflect_done
);
  import rt_pkg::*;

  vec3_t      specular_dir;
  vec3_t      diffuse_dir;
  logic [7:0] spec_roll;

  // Mirror direction
  specular_reflect spec_reflector (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_dir  (ray_dir),
    .normal  (hit_normal),
    .out_dir (specular_dir)
  );

  // Scattered direction and the specular roll of the same hit
  diffuse_scatter diff_scatter (
    .clk     (clk),
    .rst_n   (rst_n),
    .seed    (lfsr_seed),
    .step    (hit_valid),
    .normal  (hit_normal),
    .out_dir (diffuse_dir),
    .roll    (spec_roll)
  );

  reflect_blend blend (
    .clk              (clk),
    .rst_n            (rst_n),
    .hit_valid        (hit_valid),
    .ray_color        (ray_color),
    .income_light     (income_light),
    .hit_pos          (hit_pos),
    .hit_normal       (hit_normal),
    .hit_mat          (hit_mat),
    .specular_dir     (specular_dir),
    .diffuse_dir      (diffuse_dir),
    .spec_roll        (spec_roll),
    .new_dir          (new_dir),
    .new_origin       (new_origin),
    .new_color        (new_color),
    .new_income_light (new_income_light),
    .reflect_done     (reflect_done)
  );

endmodule

`default_nettype wire

//--- reflect_blend.sv
`timescale 1ns/10ps
`default_nettype none

`include "rt_defs.svh"

module reflect_blend (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    hit_valid,
  input  wire rt_pkg::color_t    ray_color,
  input  wire rt_pkg::color_t    income_light,
  input  wire rt_pkg::vec3_t     hit_pos,
  input  wire rt_pkg::vec3_t     hit_normal,
  input  wire rt_pkg::material_t hit_mat,
  input  wire rt_pkg::vec3_t     specular_dir,
  input  wire rt_pkg::vec3_t     diffuse_dir,
  input  wire [7:0]              spec_roll,
  output rt_pkg::vec3_t          new_dir,
  output rt_pkg::vec3_t          new_origin,
  output rt_pkg::color_t         new_color,
  output rt_pkg::color_t         new_income_light,
  output logic                   reflect_done
);
  import rt_pkg::*;

  // Delay line, last entry lines up with the direction units
  logic [`RT_DIR_LAT-1:0] valid_d;
  color_t    ray_color_d [`RT_DIR_LAT];
  color_t    light_d     [`RT_DIR_LAT];
  vec3_t     pos_d       [`RT_DIR_LAT];
  vec3_t     nrm_d       [`RT_DIR_LAT];
  material_t mat_d       [`RT_DIR_LAT];

  material_t mat;
  color_t    ray_color_a;
  logic      is_emit;
  logic      is_spec;
  color_t    mat_color;

  // Stage 4
  logic               valid_q4;
  logic signed [23:0] blend_x_q4;
  logic signed [23:0] blend_y_q4;
  logic signed [23:0] blend_z_q4;
  vec3_t              diffuse_q4;
  color_t             color_q4;
  color_t             emit_q4;
  color_t             light_q4;
  vec3_t              pos_q4;
  vec3_t              nrm_q4;

  function automatic color_t color_mul(input color_t a, input color_t b);
    logic [15:0] pr;
    logic [15:0] pg;
    logic [15:0] pb;
    color_t      c;
    pr  = a.r * b.r;
    pg  = a.g * b.g;
    pb  = a.b * b.b;
    c.r = pr[15:8];
    c.g = pg[15:8];
    c.b = pb[15:8];
    return c;
  endfunction

  // (spec - diff) * smoothness, still scaled by 128
  function automatic logic signed [23:0] blend_term(input fix_t s, input fix_t d,
                                                    input logic [6:0] k);
    fix_t diff;
    diff = s - d;
    return diff * $signed({1'b0, k});
  endfunction

  function automatic logic [7:0] sat_add(input logic [7:0] a, input logic [7:0] b);
    logic [8:0] sum;
    sum = a + b;
    return sum[8] ? 8'hFF : sum[7:0];
  endfunction

  always_ff @(posedge clk) begin
    ray_color_d[0] <= ray_color;
    light_d[0]     <= income_light;
    pos_d[0]       <= hit_pos;
    nrm_d[0]       <= hit_normal;
    mat_d[0]       <= hit_mat;
    for (int i = 1; i < `RT_DIR_LAT; i++) begin
      ray_color_d[i] <= ray_color_d[i-1];
      light_d[i]     <= light_d[i-1];
      pos_d[i]       <= pos_d[i-1];
      nrm_d[i]       <= nrm_d[i-1];
      mat_d[i]       <= mat_d[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_d      <= '0;
      valid_q4     <= 1'b0;
      reflect_done <= 1'b0;
    end else begin
      valid_d      <= {valid_d[`RT_DIR_LAT-2:0], hit_valid};
      valid_q4     <= valid_d[`RT_DIR_LAT-1];
      reflect_done <= valid_q4;
    end
  end

  assign mat         = mat_d[`RT_DIR_LAT-1];
  assign ray_color_a = ray_color_d[`RT_DIR_LAT-1];
  assign is_emit     = mat.emit.kind;
  // Specular only for surfaces, roll strictly below the probability
  assign is_spec     = !is_emit && (spec_roll < mat.surf.spec_prob);

  always_comb begin
    if (is_emit) begin
      mat_color = mat.emit.color;
    end else if (is_spec) begin
      mat_color = mat.surf.spec_color;
    end else begin
      mat_color = mat.surf.color;
    end
  end

  always_ff @(posedge clk) begin
    // Zero term leaves the plain diffuse direction
    if (is_spec) begin
      blend_x_q4 <= blend_term(specular_dir.x, diffuse_dir.x, mat.surf.smoothness);
      blend_y_q4 <= blend_term(specular_dir.y, diffuse_dir.y, mat.surf.smoothness);
      blend_z_q4 <= blend_term(specular_dir.z, diffuse_dir.z, mat.surf.smoothness);
    end else begin
      blend_x_q4 <= '0;
      blend_y_q4 <= '0;
      blend_z_q4 <= '0;
    end
    diffuse_q4 <= diffuse_dir;
    color_q4   <= color_mul(ray_color_a, mat_color);
    emit_q4    <= is_emit ? color_mul(ray_color_a, mat.emit.emit_color) : '0;
    light_q4   <= light_d[`RT_DIR_LAT-1];
    pos_q4     <= pos_d[`RT_DIR_LAT-1];
    nrm_q4     <= nrm_d[`RT_DIR_LAT-1];
  end

  // Outputs hold between done pulses
  always_ff @(posedge clk) begin
    if (valid_q4) begin
      new_dir.x          <= diffuse_q4.x + fix_t'(blend_x_q4 >>> 7);
      new_dir.y          <= diffuse_q4.y + fix_t'(blend_y_q4 >>> 7);
      new_dir.z          <= diffuse_q4.z + fix_t'(blend_z_q4 >>> 7);
      new_origin.x       <= pos_q4.x + (nrm_q4.x >>> `RT_ORIGIN_SHIFT);
      new_origin.y       <= pos_q4.y + (nrm_q4.y >>> `RT_ORIGIN_SHIFT);
      new_origin.z       <= pos_q4.z + (nrm_q4.z >>> `RT_ORIGIN_SHIFT);
      new_color          <= color_q4;
      new_income_light.r <= sat_add(light_q4.r, emit_q4.r);
      new_income_light.g <= sat_add(light_q4.g, emit_q4.g);
      new_income_light.b <= sat_add(light_q4.b, emit_q4.b);
    end
  end

  a_done_in_reset: assert property (@(posedge clk) !rst_n |=> !reflect_done)
    else $error("reflect_blend: reflect_done high during reset");

  // Every accepted hit comes out after both units, in step
  a_done_follows_hit: assert property (@(posedge clk) disable iff (!rst_n)
      hit_valid |-> ##(`RT_DIR_LAT + `RT_BLEND_LAT) reflect_done)
    else $error("reflect_blend: hit without reflect_done");

  // And no done appears without a hit that many cycles back
  a_done_has_hit: assert property (@(posedge clk)
      reflect_done |-> $past(hit_valid && rst_n, `RT_DIR_LAT + `RT_BLEND_LAT))
    else $error("reflect_blend: reflect_done without a hit");

endmodule

`default_nettype wire

//--- diffuse_scatter.sv
`timescale 1ns/10ps
`default_nettype none

`include "rt_defs.svh"

module diffuse_scatter (
  input  wire                clk,
  input  wire                rst_n,
  input  wire [47:0]         seed,
  input  wire                step,
  input  wire rt_pkg::vec3_t normal,
  output rt_pkg::vec3_t      out_dir,
  output logic [7:0]         roll
);
  import rt_pkg::*;

  logic [47:0] lfsr;
  logic [47:0] lfsr_next;

  // Stage 1
  logic [47:0] rnd_q1;
  vec3_t       nrm_q1;

  // Stage 2
  vec3_t       ofs_q2;
  vec3_t       nrm_q2;
  logic [7:0]  roll_q2;

  // Random slice as Q1.14, divided by 4
  function automatic fix_t quarter(input logic [15:0] s);
    return fix_t'($signed(s) >>> 2);
  endfunction

  // Right-shifting Galois step
  assign lfsr_next = {1'b0, lfsr[47:1]} ^ (lfsr[0] ? `RT_LFSR_TAPS : 48'd0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // All-zero state would lock up
      lfsr <= (seed == 48'd0) ? 48'd1 : seed;
    end else if (step) begin
      lfsr <= lfsr_next;
    end
  end

  // Hit takes the state from before its own step
  always_ff @(posedge clk) begin
    rnd_q1 <= lfsr;
    nrm_q1 <= normal;
  end

  always_ff @(posedge clk) begin
    ofs_q2.x <= quarter(rnd_q1[47:32]);
    ofs_q2.y <= quarter(rnd_q1[31:16]);
    ofs_q2.z <= quarter(rnd_q1[15:0]);
    nrm_q2   <= nrm_q1;
    roll_q2  <= rnd_q1[7:0];
  end

  // Roll leaves with the direction of the same hit
  always_ff @(posedge clk) begin
    out_dir.x <= nrm_q2.x + ofs_q2.x;
    out_dir.y <= nrm_q2.y + ofs_q2.y;
    out_dir.z <= nrm_q2.z + ofs_q2.z;
    roll      <= roll_q2;
  end

  // Generator never falls into the dead state, whatever the stepping
  a_lfsr_live: assert property (@(posedge clk) disable iff (!rst_n) lfsr != 48'd0)
    else $error("diffuse_scatter: generator state reached zero");

endmodule

`default_nettype wire

//--- specular_reflect.sv
`timescale 1ns/10ps
`default_nettype none

`include "rt_defs.svh"

module specular_reflect (
  input  wire                clk,
  input  wire                rst_n,
  input  wire rt_pkg::vec3_t in_dir,
  input  wire rt_pkg::vec3_t normal,
  output rt_pkg::vec3_t      out_dir
);
  import rt_pkg::*;

  logic signed [31:0] prod_x;
  logic signed [31:0] prod_y;
  logic signed [31:0] prod_z;
  logic signed [33:0] dot_full;

  // Stage 1
  fix_t  dot_q1;
  vec3_t dir_q1;
  vec3_t nrm_q1;

  // Stage 2
  vec3_t scaled_q2;
  vec3_t dir_q2;

  // 2*a*b in Q1.14, keeps the bit that a later doubling would lose
  function automatic fix_t twice_mul(input fix_t a, input fix_t b);
    logic signed [31:0] p;
    p = a * b;
    return p[`RT_FRAC_BITS-1 +: 16];
  endfunction

  assign prod_x   = in_dir.x * normal.x;
  assign prod_y   = in_dir.y * normal.y;
  assign prod_z   = in_dir.z * normal.z;
  assign dot_full = prod_x + prod_y + prod_z;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dot_q1    <= '0;
      dir_q1    <= '0;
      nrm_q1    <= '0;
      scaled_q2 <= '0;
      dir_q2    <= '0;
      out_dir   <= '0;
    end else begin
      // d.n, shifted once after the full sum
      dot_q1      <= dot_full[`RT_FRAC_BITS +: 16];
      dir_q1      <= in_dir;
      nrm_q1      <= normal;
      // 2(d.n)n
      scaled_q2.x <= twice_mul(dot_q1, nrm_q1.x);
      scaled_q2.y <= twice_mul(dot_q1, nrm_q1.y);
      scaled_q2.z <= twice_mul(dot_q1, nrm_q1.z);
      dir_q2      <= dir_q1;
      // Mirror about the normal, wraps on overflow
      out_dir.x   <= dir_q2.x - scaled_q2.x;
      out_dir.y   <= dir_q2.y - scaled_q2.y;
      out_dir.z   <= dir_q2.z - scaled_q2.z;
    end
  end

endmodule

`default_nettype wire

//--- rt_pkg.sv
`default_nettype none

package rt_pkg;

  // Q1.14 signed, roughly -2.0 to +2.0
  typedef logic signed [15:0] fix_t;

  typedef struct packed {
    fix_t x;
    fix_t y;
    fix_t z;
  } vec3_t;

  // 8 bits per channel, 255 is about full intensity
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } color_t;

  // Reflective surface, kind is 0
  typedef struct packed {
    logic       kind;
    color_t     color;
    color_t     spec_color;
    logic [7:0] spec_prob;
    logic [6:0] smoothness;
  } mat_surface_t;

  // Light source, kind is 1
  typedef struct packed {
    logic        kind;
    color_t      emit_color;
    color_t      color;
    logic [14:0] rsvd;
  } mat_emit_t;

  // One material word, top bit picks the view
  typedef union packed {
    mat_surface_t surf;
    mat_emit_t    emit;
  } material_t;

endpackage

`default_nettype wire

//--- rt_defs.svh
`ifndef RT_DEFS_SVH
`define RT_DEFS_SVH

// Fraction bits of a Q1.14 vector component
`define RT_FRAC_BITS 14

// Cycles through either direction unit
`define RT_DIR_LAT 3

// Cycles through the blend unit after the direction units
`define RT_BLEND_LAT 2

// New origin sits hit_normal/64 off the surface
`define RT_ORIGIN_SHIFT 6

// Feedback mask of the 48-bit Galois generator
`define RT_LFSR_TAPS 48'hB4_0000_0000_01

`endif
